//--- sbuf_config.svh
`ifndef SBUF_CONFIG_SVH
`define SBUF_CONFIG_SVH

// Store burst buffer sizing

// Entries held in the burst buffer, power of two
`define SBUF_DEPTH 16

// Largest burst issued to memory, in beats
`define SBUF_BURST_LEN 4

// Store tag coming from the issue side
`define SBUF_TAG_W 6

// One store data word
`define SBUF_DATA_W 32

`endif

//--- lsu_types_pkg.sv
`include "sbuf_config.svh"

// Types seen on the store side of the load-store unit
package lsu_types_pkg;

    // Committed store data word
    typedef logic [`SBUF_DATA_W-1:0] data_word_t;

    // Tag of the store operation, matched at writeback
    typedef logic [`SBUF_TAG_W-1:0] store_tag_t;

    // Byte address, word aligned
    typedef logic [31:0] store_addr_t;

    // Occupancy 0 to depth, one bit over the pointers
    typedef logic [$clog2(`SBUF_DEPTH):0] buf_count_t;

endpackage : lsu_types_pkg

//--- mem_bus_pkg.sv
`include "sbuf_config.svh"

// Types seen on the memory write bus
package mem_bus_pkg;

    // Byte address of the first beat
    typedef logic [31:0] mem_addr_t;

    // Beats in one burst, 1 to burst length
    typedef logic [$clog2(`SBUF_BURST_LEN):0] burst_len_t;

endpackage : mem_bus_pkg

//--- burst_buffer.sv
`timescale 1ns/1ps

`include "sbuf_config.svh"

module burst_buffer (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     push_i,       // Store enters the buffer
    input  logic                     pull_i,       // Oldest word leaves
    input  lsu_types_pkg::data_word_t data_i,
    input  lsu_types_pkg::store_tag_t tag_i,        // Tag of pushed store
    input  lsu_types_pkg::store_tag_t valid_tag_i,  // Tag written back
    input  logic                     valid_i,      // Writeback strobe
    output lsu_types_pkg::data_word_t data_o,       // Registered read
    output lsu_types_pkg::buf_count_t size_o,
    output logic                     valid_o       // Every entry validated
);

    import lsu_types_pkg::*;

    localparam int unsigned DEPTH = `SBUF_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    logic [PTR_W-1:0] push_ptr;  // Next free slot
    logic [PTR_W-1:0] pull_ptr;  // Oldest entry
    buf_count_t       count;     // One bit wider than pointers

    data_word_t mem [DEPTH];     // Circular data storage
    store_tag_t last_tag;        // Tag of the youngest store

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            push_ptr <= '0;
            pull_ptr <= '0;
        end else if (flush_i) begin
            push_ptr <= '0;
            pull_ptr <= '0;
        end else begin
            if (push_i) begin
                push_ptr <= push_ptr + 1'b1;
            end
            if (pull_i) begin
                pull_ptr <= pull_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count <= '0;
        end else if (flush_i) begin
            count <= '0;
        end else begin
            case ({push_i, pull_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither, no change
            endcase
        end
    end

    assign size_o = count;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[push_ptr] <= data_i;
        end
    end

    // Word shows up one cycle after the pull
    always_ff @(posedge clk_i) begin
        if (pull_i) begin
            data_o <= mem[pull_ptr];
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            last_tag <= tag_i;
        end
    end

    // Writeback of the youngest tag validates all older entries too
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (push_i) begin
            valid_o <= 1'b0;  // New entry not yet validated
        end else if (valid_i && (valid_tag_i == last_tag)) begin
            valid_o <= 1'b1;
        end
    end

endmodule : burst_buffer

//--- burst_address_unit.sv
`timescale 1ns/1ps

module burst_address_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      push_i,
    input  logic                      burst_start_i,  // Folds beats into base
    input  logic                      beat_i,         // One word pulled
    input  lsu_types_pkg::store_addr_t store_addr_i,
    input  logic                      empty_i,        // Buffer holds nothing
    output logic                      contig_o,
    output mem_bus_pkg::mem_addr_t    base_addr_o     // Address of oldest entry
);

    import lsu_types_pkg::*;
    import mem_bus_pkg::*;

    mem_addr_t   burst_base;  // Base at last start or first push
    store_addr_t next_addr;   // Address the next push must carry
    burst_len_t  beat_cnt;    // Beats pulled since burst_base

    // Base moves four bytes per beat pulled
    assign base_addr_o = burst_base + mem_addr_t'({beat_cnt, 2'b00});

    assign contig_o = empty_i || (store_addr_i == next_addr);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            beat_cnt <= '0;
        end else if (flush_i) begin
            beat_cnt <= '0;
        end else if (push_i && empty_i) begin
            beat_cnt <= '0;           // Fresh base
        end else if (burst_start_i) begin
            beat_cnt <= '0;           // Folded into burst_base below
        end else if (beat_i) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && empty_i) begin
            burst_base <= store_addr_i;
        end else if (burst_start_i) begin
            burst_base <= base_addr_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            next_addr <= empty_i ? store_addr_i + 32'd4 : next_addr + 32'd4;
        end
    end

endmodule : burst_address_unit

//--- burst_controller.sv
`timescale 1ns/1ps

`include "sbuf_config.svh"

module burst_controller (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      drain_i,       // Partial burst wanted
    input  logic                      all_valid_i,
    input  logic                      contig_i,
    input  logic                      mem_ready_i,
    input  lsu_types_pkg::buf_count_t count_i,
    input  mem_bus_pkg::mem_addr_t    base_addr_i,
    output logic                      pull_o,
    output logic                      burst_start_o,
    output logic                      beat_o,
    output logic                      mem_start_o,
    output logic                      mem_wvalid_o,
    output logic                      stall_o,
    output mem_bus_pkg::burst_len_t   mem_len_o,
    output mem_bus_pkg::mem_addr_t    mem_addr_o
);

    import lsu_types_pkg::*;
    import mem_bus_pkg::*;

    localparam buf_count_t FULL_COUNT  = buf_count_t'(`SBUF_DEPTH);
    localparam buf_count_t BURST_COUNT = buf_count_t'(`SBUF_BURST_LEN);

    typedef enum logic [1:0] {
        IDLE,
        START,
        BEATS
    } state_t;

    state_t     state;
    state_t     next_state;
    logic       start_cond;   // Burst may begin this cycle
    logic       last_pull;    // Final pull of the burst
    burst_len_t len_q;
    mem_addr_t  addr_q;
    burst_len_t pull_cnt;     // Pulls issued so far
    logic       wvalid_q;     // Pull delayed by read latency

    assign start_cond = all_valid_i &&
                        ((count_i >= BURST_COUNT) || (drain_i && (count_i != '0)));

    assign pull_o    = (state == BEATS) && mem_ready_i;  // Held off while not ready
    assign last_pull = pull_o && ((pull_cnt + 1'b1) == len_q);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (start_cond) next_state = START;
            START:   next_state = BEATS;
            BEATS:   if (last_pull) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
        end else if (flush_i) begin
            state <= IDLE;  // Abandon at once
        end else begin
            state <= next_state;
        end
    end

    // Length is the smaller of occupancy and burst size
    always_ff @(posedge clk_i) begin
        if ((state == IDLE) && start_cond) begin
            len_q  <= (count_i >= BURST_COUNT) ? burst_len_t'(BURST_COUNT)
                                               : burst_len_t'(count_i);
            addr_q <= base_addr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pull_cnt <= '0;
        end else if (state == START) begin
            pull_cnt <= '0;
        end else if (pull_o) begin
            pull_cnt <= pull_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wvalid_q <= 1'b0;
        end else if (flush_i) begin
            wvalid_q <= 1'b0;
        end else begin
            wvalid_q <= pull_o;
        end
    end

    assign burst_start_o = (state == START);
    assign mem_start_o   = (state == START);
    assign mem_len_o     = len_q;
    assign mem_addr_o    = addr_q;
    assign beat_o        = pull_o;   // Base follows each pulled word
    assign mem_wvalid_o  = wvalid_q;

    // Full, busy, or store would break the address run
    assign stall_o = (count_i == FULL_COUNT) || (state != IDLE) || !contig_i;

endmodule : burst_controller

//--- store_burst_unit.sv
`timescale 1ns/1ps

module store_burst_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      store_push_i,
    input  logic                      wb_valid_i,
    input  logic                      drain_i,
    input  logic                      mem_ready_i,
    input  lsu_types_pkg::data_word_t  store_data_i,
    input  lsu_types_pkg::store_addr_t store_addr_i,
    input  lsu_types_pkg::store_tag_t  store_tag_i,
    input  lsu_types_pkg::store_tag_t  wb_tag_i,
    output logic                      store_stall_o,
    output logic                      mem_start_o,
    output logic                      mem_wvalid_o,
    output mem_bus_pkg::mem_addr_t    mem_addr_o,
    output mem_bus_pkg::burst_len_t   mem_len_o,
    output lsu_types_pkg::data_word_t  mem_wdata_o,
    output lsu_types_pkg::buf_count_t  buf_count_o
);

    import lsu_types_pkg::*;
    import mem_bus_pkg::*;

    buf_count_t buf_count;
    logic       buf_empty;
    logic       all_valid;
    logic       pull;         // Controller reads one word
    logic       burst_start;
    logic       beat;
    logic       contig_ok;
    mem_addr_t  base_addr;

    assign buf_empty   = (buf_count == '0);
    assign buf_count_o = buf_count;

    burst_buffer i_burst_buffer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .push_i      (store_push_i),
        .pull_i      (pull),
        .data_i      (store_data_i),
        .tag_i       (store_tag_i),
        .valid_tag_i (wb_tag_i),
        .valid_i     (wb_valid_i),
        .data_o      (mem_wdata_o),  // Lines up with mem_wvalid_o
        .size_o      (buf_count),
        .valid_o     (all_valid)
    );

    burst_address_unit i_burst_address_unit (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .push_i        (store_push_i),
        .burst_start_i (burst_start),
        .beat_i        (beat),
        .store_addr_i  (store_addr_i),
        .empty_i       (buf_empty),
        .contig_o      (contig_ok),
        .base_addr_o   (base_addr)
    );

    burst_controller i_burst_controller (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .drain_i       (drain_i),
        .all_valid_i   (all_valid),
        .contig_i      (contig_ok),
        .mem_ready_i   (mem_ready_i),
        .count_i       (buf_count),
        .base_addr_i   (base_addr),
        .pull_o        (pull),
        .burst_start_o (burst_start),
        .beat_o        (beat),
        .mem_start_o   (mem_start_o),
        .mem_wvalid_o  (mem_wvalid_o),
        .stall_o       (store_stall_o),
        .mem_len_o     (mem_len_o),
        .mem_addr_o    (mem_addr_o)
    );

endmodule : store_burst_unit

//--- tb_store_burst_unit.sv
`timescale 1ns/1ps

`include "sbuf_config.svh"

module tb_store_burst_unit;

    import lsu_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int WAIT_LIMIT = 64;   // Cycles before a wait gives up
    localparam int QUIET_WIN  = 20;   // Cycles watched for a missing start

    logic        clk_i;
    logic        rst_n_i;
    logic        flush_i;
    logic        store_push_i;
    logic        wb_valid_i;
    logic        drain_i;
    logic        mem_ready_i;
    data_word_t  store_data_i;
    store_addr_t store_addr_i;
    store_tag_t  store_tag_i;
    store_tag_t  wb_tag_i;
    logic        store_stall_o;
    logic        mem_start_o;
    logic        mem_wvalid_o;
    mem_addr_t   mem_addr_o;
    burst_len_t  mem_len_o;
    data_word_t  mem_wdata_o;
    buf_count_t  buf_count_o;

    int          mismatch_cnt = 0;
    int          fail_cnt     = 0;
    logic [15:0] lfsr_state   = 16'd47678;
    store_tag_t  next_tag     = '0;
    store_tag_t  last_tag     = '0;   // Tag of youngest pushed store
    data_word_t  sb[$];               // Pushed words in order

    store_burst_unit i_store_burst_unit (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;    // 8 ns period
    end

    // Taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic data_word_t rand_word();
        data_word_t w;
        for (int i = 0; i < `SBUF_DATA_W; i++) begin
            w[i] = lfsr_bit();        // One step per bit
        end
        return w;
    endfunction

    task automatic check_data(input data_word_t got, input data_word_t exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input burst_len_t got, input burst_len_t exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input buf_count_t got, input buf_count_t exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Present the address first, push once the stall drops
    task automatic push_store(input store_addr_t addr);
        data_word_t word;
        int         waited;
        word   = rand_word();
        waited = 0;
        @(posedge clk_i);
        store_addr_i <= addr;
        @(negedge clk_i);
        while (store_stall_o && (waited < WAIT_LIMIT)) begin
            @(negedge clk_i);
            waited++;
        end
        if (store_stall_o) begin
            fail_cnt++;
            $display("Store to %h stayed stalled at %0t, push skipped", addr, $time);
        end else begin
            @(posedge clk_i);
            store_push_i <= 1'b1;
            store_data_i <= word;
            store_tag_i  <= next_tag;
            @(posedge clk_i);
            store_push_i <= 1'b0;
            sb.push_back(word);
            last_tag = next_tag;
            next_tag++;
        end
    endtask

    task automatic write_back(input store_tag_t tag);
        @(posedge clk_i);
        wb_valid_i <= 1'b1;
        wb_tag_i   <= tag;
        @(posedge clk_i);
        wb_valid_i <= 1'b0;
    endtask

    task automatic expect_no_start(input string what);
        repeat (QUIET_WIN) begin
            @(negedge clk_i);
            if (mem_start_o) begin
                fail_cnt++;
                $display("Burst started at %0t although %s", $time, what);
            end
        end
    endtask

    // Memory side model for one burst
    task automatic collect_burst(input mem_addr_t exp_addr, input logic toggle_ready);
        int   waited;
        int   beats;
        int   exp_len;
        logic ready_prev;
        exp_len = (sb.size() < `SBUF_BURST_LEN) ? sb.size() : `SBUF_BURST_LEN;
        waited  = 0;
        beats   = 0;
        @(negedge clk_i);
        while (!mem_start_o && (waited < WAIT_LIMIT)) begin
            @(negedge clk_i);
            waited++;
        end
        if (!mem_start_o) begin
            fail_cnt++;
            $display("No burst start within %0d cycles at %0t", WAIT_LIMIT, $time);
            return;
        end
        check_addr(mem_addr_o, exp_addr, "burst address");
        check_len(mem_len_o, burst_len_t'(exp_len), "burst length");
        waited = 0;
        while ((beats < exp_len) && (waited < WAIT_LIMIT)) begin
            @(posedge clk_i);
            ready_prev = mem_ready_i;        // Level behind this beat's pull
            if (toggle_ready) begin
                mem_ready_i <= lfsr_bit();   // Random back-pressure
            end
            @(negedge clk_i);
            if (mem_wvalid_o) begin
                if (!ready_prev) begin
                    fail_cnt++;
                    $display("Beat at %0t was pulled while memory was not ready", $time);
                end
                if (sb.size() == 0) begin
                    fail_cnt++;
                    $display("Beat at %0t with no store left to match", $time);
                end else begin
                    check_data(mem_wdata_o, sb.pop_front(), "beat data");
                end
                beats++;
                waited = 0;
            end else begin
                waited++;
            end
        end
        if (beats < exp_len) begin
            fail_cnt++;
            $display("Only %0d of %0d beats arrived by %0t", beats, exp_len, $time);
        end
        @(posedge clk_i);
        mem_ready_i <= 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            if (mem_wvalid_o) beats++;       // Anything here is one too many
        end
        check_len(burst_len_t'(beats), burst_len_t'(exp_len), "beat count");
    endtask

    task automatic after_reset();
        @(negedge clk_i);
        check_flag(mem_start_o, 1'b0, "start after reset");
        check_flag(mem_wvalid_o, 1'b0, "wvalid after reset");
        check_flag(store_stall_o, 1'b0, "stall after reset");
        check_count(buf_count_o, '0, "count after reset");
    endtask

    task automatic full_burst();
        for (int i = 0; i < 4; i++) begin
            push_store(32'h0000_1000 + 4 * i);
        end
        write_back(last_tag);
        collect_burst(32'h0000_1000, 1'b0);
    endtask

    task automatic partial_validation();
        for (int i = 0; i < 4; i++) begin
            push_store(32'h0000_2040 + 4 * i);
        end
        write_back(last_tag - store_tag_t'(2));  // Older store only
        expect_no_start("only an older tag was written back");
        write_back(last_tag);
        collect_burst(32'h0000_2040, 1'b0);
    endtask

    task automatic back_pressure();
        for (int i = 0; i < 4; i++) begin
            push_store(32'h0000_3100 + 4 * i);
        end
        write_back(last_tag);
        collect_burst(32'h0000_3100, 1'b1);
    endtask

    task automatic gap_then_drain();
        push_store(32'h0000_5000);
        push_store(32'h0000_5004);
        write_back(last_tag);                // Two entries below burst size
        @(posedge clk_i);
        store_addr_i <= 32'h0000_5100;       // Breaks the run
        @(negedge clk_i);
        check_flag(store_stall_o, 1'b1, "stall on address gap");
        @(posedge clk_i);
        drain_i <= 1'b1;
        collect_burst(32'h0000_5000, 1'b0);
        @(posedge clk_i);
        drain_i <= 1'b0;
        push_store(32'h0000_5100);           // New base
        @(negedge clk_i);
        check_count(buf_count_o, buf_count_t'(1), "count after new base");
        write_back(last_tag);
        drain_i <= 1'b1;
        collect_burst(32'h0000_5100, 1'b0);
        @(posedge clk_i);
        drain_i <= 1'b0;
    endtask

    task automatic flush_before_start();
        for (int i = 0; i < 4; i++) begin
            push_store(32'h0000_6000 + 4 * i);
        end
        @(posedge clk_i);
        wb_valid_i <= 1'b1;
        wb_tag_i   <= last_tag;
        @(posedge clk_i);
        wb_valid_i <= 1'b0;
        flush_i    <= 1'b1;                  // Lands on the edge that would start
        @(posedge clk_i);
        flush_i    <= 1'b0;
        sb.delete();
        @(negedge clk_i);
        check_count(buf_count_o, '0, "count after flush");
        check_flag(store_stall_o, 1'b0, "stall after flush");
        expect_no_start("the buffer was flushed");
    endtask

    initial begin
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        store_push_i = 1'b0;
        wb_valid_i   = 1'b0;
        drain_i      = 1'b0;
        mem_ready_i  = 1'b1;
        store_data_i = '0;
        store_addr_i = '0;
        store_tag_i  = '0;
        wb_tag_i     = '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        after_reset();
        full_burst();
        partial_validation();
        back_pressure();
        gap_then_drain();
        flush_before_start();

        $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if ((mismatch_cnt + fail_cnt) == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_store_burst_unit

//--- src.f
+incdir+.
lsu_types_pkg.sv
mem_bus_pkg.sv
burst_buffer.sv
burst_address_unit.sv
burst_controller.sv
store_burst_unit.sv
tb_store_burst_unit.sv

//--- Bender.yml
package:
  name: store_burst_unit

sources:
  - include_dirs:
      - .
    files:
      - lsu_types_pkg.sv
      - mem_bus_pkg.sv
      - burst_buffer.sv
      - burst_address_unit.sv
      - burst_controller.sv
      - store_burst_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_store_burst_unit.sv
